/* bench/fetch_front_tb.sv */
// Fetch front end testbench
module fetch_front_tb;

  // Cycles any single wait may take before the run gives up
  localparam int TIMEOUT = 2000;

  logic                clk;
  logic                rst_n;
  logic                ibus_req_o;
  ibus_pkg::addr_t     ibus_addr_o;
  logic                ibus_gnt_i;
  logic                ibus_rvalid_i;
  ibus_pkg::data_t     ibus_rdata_i;
  logic                halt_if_i;
  logic                kill_if_i;
  logic                branch_i;
  ibus_pkg::addr_t     branch_addr_i;
  fetch_pkg::privlvl_t branch_priv_i;
  logic                dummy_en_i;
  logic                id_ready_i;
  logic                if_valid_o;
  ibus_pkg::data_t     if_instr_o;
  ibus_pkg::addr_t     if_pc_o;
  fetch_pkg::privlvl_t if_priv_o;
  logic                if_dummy_o;

  integer seed = 32'hdd95_e662;

  // The bus model keeps one entry per granted request in request order
  ibus_pkg::addr_t pend_addr[$];
  int              pend_due[$];
  ibus_pkg::addr_t resp_addr;
  int              cycle;
  int              gnt_pct;
  logic            ready_random;

  // The expected stream advances only on words accepted by decode and on redirects
  ibus_pkg::addr_t     exp_pc;
  fetch_pkg::privlvl_t exp_priv;
  int                  exp_cnt;
  logic                exp_dummy_en;

  // Bookkeeping for the report
  string test_name;
  int    passed;
  int    dummies;
  int    check_cnt;
  int    error_cnt;
  int    test_errors;
  int    test_base;
  int    test_cnt;
  logic  timed_out;

  fetch_front fetch_front_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Memory contents are the address rotated left by 7 and scrambled
  function automatic ibus_pkg::data_t ref_instr(input ibus_pkg::addr_t addr);
    ref_instr = {addr[24:0], addr[31:25]} ^ 32'ha5a5_0f0f;
  endfunction

  function automatic int rand_below(input int n);
    rand_below = ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  task automatic note_error();
    error_cnt   = error_cnt + 1;
    test_errors = test_errors + 1;
  endtask

  task automatic check_instr(input ibus_pkg::addr_t exp_pc_v, input ibus_pkg::data_t exp_word,
                             input ibus_pkg::addr_t act_pc_v, input ibus_pkg::data_t act_word);
    check_cnt = check_cnt + 1;
    if (act_pc_v !== exp_pc_v || act_word !== exp_word) begin
      $display("CHECK FAILED %s: expected pc %h instr %h, actual pc %h instr %h",
               test_name, exp_pc_v, exp_word, act_pc_v, act_word);
      note_error();
    end
  endtask

  task automatic check_priv(input fetch_pkg::privlvl_t exp_lvl,
                            input fetch_pkg::privlvl_t act_lvl);
    check_cnt = check_cnt + 1;
    if (act_lvl !== exp_lvl) begin
      $display("CHECK FAILED %s: expected priv %b, actual priv %b at pc %h",
               test_name, exp_lvl, act_lvl, if_pc_o);
      note_error();
    end
  endtask

  task automatic check_dummy(input logic exp_flag, input logic act_flag);
    check_cnt = check_cnt + 1;
    if (act_flag !== exp_flag) begin
      $display("CHECK FAILED %s: expected dummy %b, actual dummy %b at pc %h",
               test_name, exp_flag, act_flag, if_pc_o);
      note_error();
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
    test_base   = passed;
    dummies     = 0;
  endtask

  task automatic end_test();
    test_cnt = test_cnt + 1;
    $display("Test %s done: %0d instructions, %0d dummies, %0d errors",
             test_name, passed - test_base, dummies, test_errors);
  endtask

  // Wait until decode has taken n more instructions
  task automatic wait_passed(input int n);
    int target;
    int waited;
    target = passed + n;
    waited = 0;
    while (passed < target && !timed_out) begin
      @(negedge clk);
      waited = waited + 1;
      if (waited > TIMEOUT) begin
        $display("Timeout in %s: only %0d of %0d instructions reached decode",
                 test_name, n - (target - passed), n);
        timed_out = 1'b1;
        error_cnt = error_cnt + 1;
      end
    end
  endtask

  // Gives a one-cycle kill with branch while a request is on the bus
  // Decode stays ready in the kill cycle so the word in the pipe register is not lost
  task automatic redirect_fetch(input ibus_pkg::addr_t target, input fetch_pkg::privlvl_t priv,
                                input logic dummy_en);
    int waited;
    waited = 0;
    ready_random = 1'b0;
    @(negedge clk);
    while (pend_addr.size() == 0 && !timed_out) begin
      @(negedge clk);
      waited = waited + 1;
      if (waited > TIMEOUT) begin
        $display("Timeout in %s: no request became outstanding before the branch", test_name);
        timed_out = 1'b1;
        error_cnt = error_cnt + 1;
      end
    end
    kill_if_i     = 1'b1;
    branch_i      = 1'b1;
    branch_addr_i = target;
    branch_priv_i = priv;
    dummy_en_i    = dummy_en;
    @(negedge clk);
    kill_if_i = 1'b0;
    branch_i  = 1'b0;
  endtask

  //////////////////////////////
  // Bus model and decode ready
  //////////////////////////////

  // Grants are decided here since req and addr are stable until the next rising edge
  always @(negedge clk) begin
    cycle = cycle + 1;
    ibus_rvalid_i = 1'b0;
    if (pend_due.size() > 0 && cycle >= pend_due[0]) begin
      resp_addr     = pend_addr.pop_front();
      void'(pend_due.pop_front());
      ibus_rvalid_i = 1'b1;
      ibus_rdata_i  = ref_instr(resp_addr);
    end
    ibus_gnt_i = (rand_below(100) < gnt_pct);
    if (ibus_req_o && ibus_gnt_i) begin
      if (pend_addr.size() >= ibus_pkg::MAX_OUTSTANDING) begin
        $display("Error in %s: request granted with %0d requests already outstanding",
                 test_name, pend_addr.size());
        note_error();
      end
      pend_addr.push_back(ibus_addr_o);
      // The delay is 1 to 4 cycles and later entries still wait for the head
      pend_due.push_back(cycle + 1 + rand_below(4));
    end
    id_ready_i = ready_random ? (rand_below(4) != 0) : 1'b1;
  end

  //////////////////////////////
  // Compare process
  //////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      if (if_valid_o && id_ready_i) begin
        passed = passed + 1;
        if (exp_dummy_en && exp_cnt == fetch_pkg::DUMMY_INTERVAL) begin
          // A dummy shows the pc of the real word that follows it
          check_dummy(1'b1, if_dummy_o);
          check_instr(exp_pc, fetch_pkg::DUMMY_INSTR, if_pc_o, if_instr_o);
          exp_cnt = 0;
          dummies = dummies + 1;
        end else begin
          check_dummy(1'b0, if_dummy_o);
          check_instr(exp_pc, ref_instr(exp_pc), if_pc_o, if_instr_o);
          exp_pc = exp_pc + 32'd4;
          if (exp_cnt < fetch_pkg::DUMMY_INTERVAL) begin
            exp_cnt = exp_cnt + 1;
          end
        end
        check_priv(exp_priv, if_priv_o);
      end
      // The word taken in the kill cycle is still from the old path
      if (kill_if_i && branch_i) begin
        exp_pc       = branch_addr_i;
        exp_priv     = branch_priv_i;
        exp_dummy_en = dummy_en_i;
      end
    end
  end

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial begin
    int halt_base;
    int hold;
    rst_n         = 1'b0;
    ibus_gnt_i    = 1'b0;
    ibus_rvalid_i = 1'b0;
    ibus_rdata_i  = '0;
    halt_if_i     = 1'b0;
    kill_if_i     = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    branch_priv_i = fetch_pkg::PRIV_LVL_M;
    dummy_en_i    = 1'b0;
    id_ready_i    = 1'b1;
    ready_random  = 1'b0;
    gnt_pct       = 100;
    cycle         = 0;
    exp_pc        = fetch_pkg::BOOT_ADDR;
    exp_priv      = fetch_pkg::PRIV_LVL_M;
    exp_cnt       = 0;
    exp_dummy_en  = 1'b0;
    passed        = 0;
    check_cnt     = 0;
    error_cnt     = 0;
    test_cnt      = 0;
    timed_out     = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    start_test("sequential_boot");
    wait_passed(20);
    end_test();

    start_test("back_pressure");
    gnt_pct      = 60;
    ready_random = 1'b1;
    wait_passed(200);
    end_test();

    start_test("branch_flush");
    for (int i = 0; i < 3; i++) begin
      ready_random = 1'b1;
      wait_passed(10);
      redirect_fetch(ibus_pkg::addr_t'($random(seed)) & 32'hffff_fffc,
                     fetch_pkg::PRIV_LVL_M, 1'b0);
      ready_random = 1'b1;
      wait_passed(30);
    end
    end_test();

    start_test("halt");
    ready_random = 1'b0;
    gnt_pct      = 100;
    wait_passed(5);
    @(negedge clk);
    halt_if_i = 1'b1;
    halt_base = passed;
    hold      = 3 + rand_below(10);
    repeat (hold) @(negedge clk);
    // Only the word already in the pipe register may leave during halt
    if (passed - halt_base > 1) begin
      $display("Error in halt: %0d instructions reached decode while fetch was halted",
               passed - halt_base);
      note_error();
    end
    halt_if_i = 1'b0;
    wait_passed(20);
    end_test();

    start_test("dummy_insertion");
    redirect_fetch(32'h0000_1000, fetch_pkg::PRIV_LVL_M, 1'b1);
    ready_random = 1'b1;
    wait_passed(50);
    end_test();

    start_test("privilege_change");
    redirect_fetch(32'h0000_4000, fetch_pkg::PRIV_LVL_U, 1'b1);
    ready_random = 1'b1;
    wait_passed(30);
    redirect_fetch(32'h0000_0200, fetch_pkg::PRIV_LVL_M, 1'b1);
    ready_random = 1'b1;
    wait_passed(20);
    end_test();

    $display("Summary: %0d tests, %0d instructions, %0d checks, %0d errors",
             test_cnt, passed, check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* fetch_front.f */
source/ibus_pkg.sv
source/fetch_pkg.sv
source/prefetch_resp_if.sv
source/prefetcher.sv
source/fetch_stage_checks.sv
source/fetch_stage.sv
source/fetch_front.sv
bench/fetch_front_tb.sv

/* source/fetch_front.sv */
// Instruction fetch front end
module fetch_front (
  input  logic                clk,
  input  logic                rst_n,
  // Instruction bus
  output logic                ibus_req_o,
  output ibus_pkg::addr_t     ibus_addr_o,
  input  logic                ibus_gnt_i,
  input  logic                ibus_rvalid_i,
  input  ibus_pkg::data_t     ibus_rdata_i,
  // Controller
  input  logic                halt_if_i,
  input  logic                kill_if_i,
  input  logic                branch_i,
  input  ibus_pkg::addr_t     branch_addr_i,
  input  fetch_pkg::privlvl_t branch_priv_i,
  input  logic                dummy_en_i,
  // Decode side
  input  logic                id_ready_i,
  output logic                if_valid_o,
  output ibus_pkg::data_t     if_instr_o,
  output ibus_pkg::addr_t     if_pc_o,
  output fetch_pkg::privlvl_t if_priv_o,
  output logic                if_dummy_o
);

  fetch_pkg::ctrl_fsm_t   ctrl;
  fetch_pkg::if_id_pipe_t if_id_pipe;

  // Buffered words from prefetcher to fetch stage
  prefetch_resp_if resp_if ();

  // Controller command, shared by both halves
  assign ctrl.halt_if     = halt_if_i;
  assign ctrl.kill_if     = kill_if_i;
  assign ctrl.branch      = branch_i;
  assign ctrl.branch_addr = branch_addr_i;
  assign ctrl.branch_priv = branch_priv_i;

  prefetcher prefetcher_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_i        (ctrl),
    .ibus_req_o    (ibus_req_o),
    .ibus_addr_o   (ibus_addr_o),
    .ibus_gnt_i    (ibus_gnt_i),
    .ibus_rvalid_i (ibus_rvalid_i),
    .ibus_rdata_i  (ibus_rdata_i),
    .resp          (resp_if.source)
  );

  fetch_stage fetch_stage_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl),
    .dummy_en_i   (dummy_en_i),
    .resp         (resp_if.sink),
    .id_ready_i   (id_ready_i),
    .if_id_pipe_o (if_id_pipe)
  );

  assign if_valid_o = if_id_pipe.instr_valid;
  assign if_instr_o = if_id_pipe.instr;
  assign if_pc_o    = if_id_pipe.pc;
  assign if_priv_o  = if_id_pipe.priv_lvl;
  assign if_dummy_o = if_id_pipe.dummy;

endmodule

/* source/fetch_pkg.sv */
// Fetch pipeline types
package fetch_pkg;

  //////////////////////////////
  // Types
  //////////////////////////////

  // Privilege level, encoded as in the machine status register
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } privlvl_t;

  // Command from the controller FSM
  // A redirect is kill_if together with branch
  typedef struct packed {
    logic            halt_if;
    logic            kill_if;
    logic            branch;
    ibus_pkg::addr_t branch_addr;
    privlvl_t        branch_priv;
  } ctrl_fsm_t;

  // Pipeline register between fetch and decode
  typedef struct packed {
    logic            instr_valid;
    ibus_pkg::data_t instr;
    ibus_pkg::addr_t pc;
    privlvl_t        priv_lvl;
    logic            dummy;
  } if_id_pipe_t;

  //////////////////////////////
  // Constants
  //////////////////////////////

  // First fetch address after reset
  localparam ibus_pkg::addr_t BOOT_ADDR = 32'h0000_0080;

  // Real instructions passed on between two dummies
  localparam int DUMMY_INTERVAL = 4;
  // Wide enough to hold DUMMY_INTERVAL, where the counter saturates
  localparam int DUMMY_CNT_W = $clog2(DUMMY_INTERVAL + 1);

  // A dummy is issued as the canonical NOP (addi x0, x0, 0)
  localparam ibus_pkg::data_t DUMMY_INSTR = 32'h0000_0013;

endpackage

/* source/fetch_stage.sv */
// Fetch stage
module fetch_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  fetch_pkg::ctrl_fsm_t   ctrl_i,
  input  logic                   dummy_en_i,
  prefetch_resp_if.sink          resp,
  input  logic                   id_ready_i,
  output fetch_pkg::if_id_pipe_t if_id_pipe_o
);

  logic                              if_ready;
  logic                              if_valid;
  logic                              pipe_free;
  logic                              dummy_insert;
  logic                              load;
  // Real instructions passed on since the last dummy, saturating
  logic [fetch_pkg::DUMMY_CNT_W-1:0] dummy_cnt_q;

  // Pipe register, valid is control and the rest is payload
  logic                              pipe_valid_q;
  ibus_pkg::data_t                   pipe_instr_q;
  ibus_pkg::addr_t                   pipe_pc_q;
  fetch_pkg::privlvl_t               pipe_priv_q;
  logic                              pipe_dummy_q;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  // The pipe register can take a word if it is empty or being read this cycle
  assign pipe_free = !pipe_valid_q || id_ready_i;

  // Kill drains the buffer, halt freezes it
  assign if_ready = ctrl_i.kill_if || (!ctrl_i.halt_if && pipe_free);
  assign if_valid = resp.valid && !ctrl_i.halt_if && !ctrl_i.kill_if;
  assign load     = if_valid && if_ready;

  // A dummy takes the slot of the waiting word, which stays in the buffer
  assign dummy_insert = dummy_en_i && (dummy_cnt_q == fetch_pkg::DUMMY_INTERVAL) && load;

  assign resp.ready = if_ready && !dummy_insert;

  //////////////////////////////
  // Pipe register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pipe_valid_q <= 1'b0;
      dummy_cnt_q  <= '0;
    end else begin
      if (ctrl_i.kill_if) begin
        pipe_valid_q <= 1'b0;
      end else if (load) begin
        pipe_valid_q <= 1'b1;
      end else if (id_ready_i) begin
        pipe_valid_q <= 1'b0;
      end
      // With dummies disabled the count rests at the interval
      if (dummy_insert) begin
        dummy_cnt_q <= '0;
      end else if (load && (dummy_cnt_q < fetch_pkg::DUMMY_INTERVAL)) begin
        dummy_cnt_q <= dummy_cnt_q + 1'b1;
      end
    end
  end

  // A dummy carries the pc and level of the word it was placed before
  always_ff @(posedge clk) begin
    if (load) begin
      pipe_instr_q <= dummy_insert ? fetch_pkg::DUMMY_INSTR : resp.instr;
      pipe_pc_q    <= resp.pc;
      pipe_priv_q  <= resp.priv_lvl;
      pipe_dummy_q <= dummy_insert;
    end
  end

  assign if_id_pipe_o.instr_valid = pipe_valid_q;
  assign if_id_pipe_o.instr       = pipe_instr_q;
  assign if_id_pipe_o.pc          = pipe_pc_q;
  assign if_id_pipe_o.priv_lvl    = pipe_priv_q;
  assign if_id_pipe_o.dummy       = pipe_dummy_q;

  fetch_stage_checks checks_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .if_ready_i     (if_ready),
    .if_valid_i     (if_valid),
    .pc_if_i        (resp.pc),
    .resp_valid_i   (resp.valid),
    .ctrl_i         (ctrl_i),
    .resp_priv_i    (resp.priv_lvl),
    .dummy_insert_i (dummy_insert),
    .if_id_pipe_i   (if_id_pipe_o)
  );

endmodule

/* source/fetch_stage_checks.sv */
// Fetch stage checks
module fetch_stage_checks (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   if_ready_i,
  input  logic                   if_valid_i,
  input  ibus_pkg::addr_t        pc_if_i,
  input  logic                   resp_valid_i,
  input  fetch_pkg::ctrl_fsm_t   ctrl_i,
  input  fetch_pkg::privlvl_t    resp_priv_i,
  input  logic                   dummy_insert_i,
  input  fetch_pkg::if_id_pipe_t if_id_pipe_i
);

  // Set when an offered word shows a new level, cleared once decode sees a word
  logic                priv_lvl_change_q;
  // Level of the last word offered by the buffer
  fetch_pkg::privlvl_t new_priv_lvl_q;

  // Only valid words count, an empty buffer shows stale contents
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      priv_lvl_change_q <= 1'b0;
      new_priv_lvl_q    <= fetch_pkg::PRIV_LVL_M;
    end else begin
      if (if_id_pipe_i.instr_valid) begin
        priv_lvl_change_q <= 1'b0;
      end
      if (resp_valid_i) begin
        new_priv_lvl_q <= resp_priv_i;
        if (resp_priv_i != new_priv_lvl_q) begin
          priv_lvl_change_q <= 1'b1;
        end
      end
    end
  end

  a_halt :
    assert property (@(posedge clk) disable iff (!rst_n)
                     ctrl_i.halt_if && !ctrl_i.kill_if |-> !if_ready_i && !if_valid_i)
      else $error("fetch_stage: halt must block ready and valid");

  a_kill :
    assert property (@(posedge clk) disable iff (!rst_n)
                     ctrl_i.kill_if |-> if_ready_i && !if_valid_i)
      else $error("fetch_stage: kill must force ready and block valid");

  // The first word to reach decode after a level change carries the new level
  a_priv_lvl_change :
    assert property (@(posedge clk) disable iff (!rst_n)
                     priv_lvl_change_q && if_id_pipe_i.instr_valid
                     |-> (if_id_pipe_i.priv_lvl == new_priv_lvl_q))
      else $error("fetch_stage: wrong privilege level passed to decode");

  // The buffer head must survive a dummy so the real word follows it
  a_no_pop_on_dummy :
    assert property (@(posedge clk) disable iff (!rst_n)
                     dummy_insert_i && resp_valid_i && !ctrl_i.kill_if
                     |=> ctrl_i.kill_if || (pc_if_i == $past(pc_if_i)))
      else $error("fetch_stage: buffer popped during dummy");

  a_no_back_to_back_dummy :
    assert property (@(posedge clk) disable iff (!rst_n)
                     dummy_insert_i |=> !dummy_insert_i)
      else $error("fetch_stage: dummy inserted two cycles in a row");

endmodule

/* source/ibus_pkg.sv */
// Instruction bus definitions
package ibus_pkg;

  // Address and data widths of the instruction bus
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Requests that may be in flight at once
  // The response buffer has the same depth, so a granted word always has a slot
  localparam int MAX_OUTSTANDING = 2;

  // Counters must hold the value MAX_OUTSTANDING itself
  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);
  // Buffer pointers wrap naturally since the depth is a power of two
  localparam int PTR_W = $clog2(MAX_OUTSTANDING);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [CNT_W-1:0]  cnt_t;

endpackage

/* source/prefetch_resp_if.sv */
// Prefetch response channel
interface prefetch_resp_if;

  // The head of the response buffer is offered while valid is high
  // A word moves when valid and ready are both high at a clock edge
  logic                valid;
  logic                ready;
  ibus_pkg::data_t     instr;
  ibus_pkg::addr_t     pc;
  fetch_pkg::privlvl_t priv_lvl;

  // Prefetcher side
  modport source (
    output valid,
    output instr,
    output pc,
    output priv_lvl,
    input  ready
  );

  // Fetch stage side
  modport sink (
    input  valid,
    input  instr,
    input  pc,
    input  priv_lvl,
    output ready
  );

endinterface

/* source/prefetcher.sv */
// Instruction prefetcher
module prefetcher (
  input  logic                 clk,
  input  logic                 rst_n,
  input  fetch_pkg::ctrl_fsm_t ctrl_i,
  output logic                 ibus_req_o,
  output ibus_pkg::addr_t      ibus_addr_o,
  input  logic                 ibus_gnt_i,
  input  logic                 ibus_rvalid_i,
  input  ibus_pkg::data_t      ibus_rdata_i,
  prefetch_resp_if.source      resp
);

  // Fetch starts one clock after reset is released
  logic                       fetch_en_q;
  // Next address to request, and the pc of the next response that is kept
  ibus_pkg::addr_t            fetch_addr_q;
  ibus_pkg::addr_t            fetch_addr_d;
  ibus_pkg::addr_t            resp_pc_q;
  // Privilege level given to every word requested from now on
  fetch_pkg::privlvl_t        priv_q;
  // All requests on the bus, and how many of the oldest ones are stale
  ibus_pkg::cnt_t             out_cnt_q;
  ibus_pkg::cnt_t             out_cnt_d;
  ibus_pkg::cnt_t             drop_cnt_q;
  ibus_pkg::cnt_t             buf_cnt_q;
  logic [ibus_pkg::PTR_W-1:0] wr_ptr_q;
  logic [ibus_pkg::PTR_W-1:0] rd_ptr_q;
  ibus_pkg::data_t            buf_instr_q [ibus_pkg::MAX_OUTSTANDING];
  ibus_pkg::addr_t            buf_pc_q    [ibus_pkg::MAX_OUTSTANDING];
  fetch_pkg::privlvl_t        buf_priv_q  [ibus_pkg::MAX_OUTSTANDING];
  logic                       redirect;
  logic                       gnt_ok;
  logic                       resp_keep;
  logic                       pop;

  //////////////////////////////
  // Bus request side
  //////////////////////////////

  assign redirect = ctrl_i.kill_if && ctrl_i.branch;

  // Words on the bus plus words buffered may never exceed the buffer depth
  assign ibus_req_o  = fetch_en_q && ((out_cnt_q + buf_cnt_q) < ibus_pkg::MAX_OUTSTANDING);
  assign ibus_addr_o = fetch_addr_q;
  assign gnt_ok      = ibus_req_o && ibus_gnt_i;

  // A grant in the kill cycle still goes out on the old path and is dropped later
  assign fetch_addr_d = redirect ? ctrl_i.branch_addr :
                        gnt_ok   ? fetch_addr_q + 32'd4 : fetch_addr_q;

  assign out_cnt_d = out_cnt_q + ibus_pkg::cnt_t'(gnt_ok) - ibus_pkg::cnt_t'(ibus_rvalid_i);

  // Responses owed to requests from before a kill are thrown away on arrival
  assign resp_keep = ibus_rvalid_i && (drop_cnt_q == '0) && !ctrl_i.kill_if;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_en_q   <= 1'b0;
      fetch_addr_q <= fetch_pkg::BOOT_ADDR;
      resp_pc_q    <= fetch_pkg::BOOT_ADDR;
      priv_q       <= fetch_pkg::PRIV_LVL_M;
      out_cnt_q    <= '0;
      drop_cnt_q   <= '0;
    end else begin
      fetch_en_q   <= 1'b1;
      fetch_addr_q <= fetch_addr_d;
      out_cnt_q    <= out_cnt_d;
      if (ctrl_i.kill_if) begin
        // Everything still on the bus after this edge belongs to the old path
        resp_pc_q  <= fetch_addr_d;
        drop_cnt_q <= out_cnt_d;
      end else begin
        if (resp_keep) begin
          resp_pc_q <= resp_pc_q + 32'd4;
        end
        if (ibus_rvalid_i && (drop_cnt_q != '0)) begin
          drop_cnt_q <= drop_cnt_q - 1'b1;
        end
      end
      if (redirect) begin
        priv_q <= ctrl_i.branch_priv;
      end
    end
  end

  //////////////////////////////
  // Response buffer
  //////////////////////////////

  assign pop = resp.valid && resp.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      buf_cnt_q <= '0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
    end else if (ctrl_i.kill_if) begin
      // The word handed over in this cycle is discarded by the fetch stage
      buf_cnt_q <= '0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
    end else begin
      buf_cnt_q <= buf_cnt_q + ibus_pkg::cnt_t'(resp_keep) - ibus_pkg::cnt_t'(pop);
      if (resp_keep) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (resp_keep) begin
      buf_instr_q[wr_ptr_q] <= ibus_rdata_i;
      buf_pc_q[wr_ptr_q]    <= resp_pc_q;
      buf_priv_q[wr_ptr_q]  <= priv_q;
    end
  end

  assign resp.valid    = (buf_cnt_q != '0);
  assign resp.instr    = buf_instr_q[rd_ptr_q];
  assign resp.pc       = buf_pc_q[rd_ptr_q];
  assign resp.priv_lvl = buf_priv_q[rd_ptr_q];

  // Branch targets come from the controller, so alignment is checked at the bus
  a_addr_aligned :
    assert property (@(posedge clk) disable iff (!rst_n)
                     ibus_req_o |-> (ibus_addr_o[1:0] == 2'b00))
      else $error("prefetcher: unaligned fetch address");

  // A response without a request or a grant past the limit overflows this sum
  a_outstanding_limit :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (out_cnt_q + buf_cnt_q) <= ibus_pkg::MAX_OUTSTANDING)
      else $error("prefetcher: too many requests outstanding");

  // A pending request keeps its address until granted, unless the path is killed
  a_addr_stable :
    assert property (@(posedge clk) disable iff (!rst_n)
                     ibus_req_o && !ibus_gnt_i && !ctrl_i.kill_if
                     |=> ibus_req_o && $stable(ibus_addr_o))
      else $error("prefetcher: request changed while waiting for grant");

endmodule
